//--- files.f
rtl/sipo_ctrl_pkg.sv
rtl/frame_pkg.sv
rtl/button_sync.sv
rtl/cycle_counter.sv
rtl/sipo_controller.sv
rtl/sipo_shift_reg.sv
rtl/frame_decoder.sv
rtl/sipo_top.sv
sim/sipo_tb.sv

//--- rtl/button_sync.sv
`timescale 1ns/1ps
`default_nettype none

module button_sync
(
    input  wire  clk2,
    input  wire  reset_b,
    input  wire  button,
    output logic control_signal
);

    logic                                   sync_q1;
    logic                                   sync_q2;
    logic [sipo_ctrl_pkg::debounce_width-1:0] deb_cnt;

    // Two-flop synchronizer.
    always_ff @(posedge clk2 or negedge reset_b)
    begin
        if (!reset_b)
        begin
            sync_q1 <= 1'b0;
            sync_q2 <= 1'b0;
        end
        else
        begin
            sync_q1 <= button;
            sync_q2 <= sync_q1;
        end
    end

    // Output follows only after a run of differing samples.
    always_ff @(posedge clk2 or negedge reset_b)
    begin
        if (!reset_b)
        begin
            deb_cnt        <= '0;
            control_signal <= 1'b0;
        end
        else if (sync_q2 == control_signal)
        begin
            deb_cnt <= '0;
        end
        else if (deb_cnt == sipo_ctrl_pkg::debounce_last)
        begin
            deb_cnt        <= '0;
            control_signal <= sync_q2;
        end
        else
        begin
            deb_cnt <= deb_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/cycle_counter.sv
`timescale 1ns/1ps
`default_nettype none

module cycle_counter
(
    input  wire                                     clk2,
    input  wire                                     reset_b,
    input  wire  [1:0]                              counter_sel,
    output logic [sipo_ctrl_pkg::counter_width-1:0] counter_value
);

    always_ff @(posedge clk2 or negedge reset_b)
    begin
        if (!reset_b)
        begin
            counter_value <= '0;
        end
        else
        begin
            case (counter_sel)
                sipo_ctrl_pkg::cnt_sel_clear: counter_value <= '0;
                sipo_ctrl_pkg::cnt_sel_count: counter_value <= counter_value + 1'b1;
                // Hold, and the unused code.
                default:                      counter_value <= counter_value;
            endcase
        end
    end

    a_clear_to_zero: assert property (
        @(posedge clk2) disable iff (!reset_b)
        counter_sel == sipo_ctrl_pkg::cnt_sel_clear |=> counter_value == '0
    );

endmodule

`default_nettype wire

//--- rtl/frame_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module frame_decoder
(
    input  wire                                 clk2,
    input  wire                                 reset_b,
    input  wire                                 data_ready,
    input  wire  frame_pkg::frame_word_u        frame,
    output logic                                frame_done,
    output logic [frame_pkg::data_bits-1:0]     data_byte,
    output logic                                parity_error,
    output logic                                framing_error
);

    logic ready_q;
    logic ready_rise;

    assign ready_rise = data_ready && !ready_q;

    always_ff @(posedge clk2 or negedge reset_b)
    begin
        if (!reset_b)
        begin
            ready_q       <= 1'b0;
            frame_done    <= 1'b0;
            parity_error  <= 1'b0;
            framing_error <= 1'b0;
        end
        else
        begin
            ready_q    <= data_ready;
            frame_done <= ready_rise;
            if (ready_rise)
            begin
                // Even parity over data and parity bit.
                parity_error  <= ^{frame.fields.data, frame.fields.parity};
                framing_error <= frame.fields.start || !frame.fields.stop;
            end
        end
    end

    always_ff @(posedge clk2)
    begin
        if (ready_rise)
            data_byte <= frame.fields.data;
    end

endmodule

`default_nettype wire

//--- rtl/frame_pkg.sv
`default_nettype none

package frame_pkg;

    localparam int frame_bits = 11;
    localparam int data_bits  = 8;

    // Field layout, first bit on the wire at the top.
    typedef struct packed
    {
        logic                 start;
        logic [data_bits-1:0] data;
        logic                 parity;
        logic                 stop;
    } frame_fields_t;

    // Same word seen as shifted bits or as frame fields.
    typedef union packed
    {
        logic [frame_bits-1:0] raw;
        frame_fields_t         fields;
    } frame_word_u;

endpackage

`default_nettype wire

//--- rtl/sipo_controller.sv
`timescale 1ns/1ps
`default_nettype none

module sipo_controller
(
    input  wire                                     clk2,
    input  wire                                     reset_b,
    input  wire                                     control_signal,
    input  wire  [sipo_ctrl_pkg::counter_width-1:0] counter_value,
    output logic [1:0]                              counter_sel,
    output logic                                    data_logging,
    output logic                                    data_ready
);

    sipo_ctrl_pkg::ctrl_state_e state_q;
    sipo_ctrl_pkg::ctrl_state_e state_d;

    always_ff @(posedge clk2 or negedge reset_b)
    begin
        if (!reset_b)
            state_q <= sipo_ctrl_pkg::st_idle;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        counter_sel  = sipo_ctrl_pkg::cnt_sel_clear;
        data_logging = 1'b0;
        data_ready   = 1'b0;
        state_d      = state_q;
        case (state_q)
            sipo_ctrl_pkg::st_idle:
            begin
                if (control_signal)
                    state_d = sipo_ctrl_pkg::st_armed;
            end
            // Wait for the release.
            sipo_ctrl_pkg::st_armed:
            begin
                if (!control_signal)
                    state_d = sipo_ctrl_pkg::st_lead_in;
            end
            sipo_ctrl_pkg::st_lead_in:
            begin
                counter_sel = sipo_ctrl_pkg::cnt_sel_count;
                if (counter_value == sipo_ctrl_pkg::lead_in_last)
                    state_d = sipo_ctrl_pkg::st_logging;
            end
            sipo_ctrl_pkg::st_logging:
            begin
                counter_sel  = sipo_ctrl_pkg::cnt_sel_count;
                data_logging = 1'b1;
                if (counter_value == sipo_ctrl_pkg::logging_last)
                    state_d = sipo_ctrl_pkg::st_ready;
            end
            // New press starts another capture.
            sipo_ctrl_pkg::st_ready:
            begin
                counter_sel = sipo_ctrl_pkg::cnt_sel_hold;
                data_ready  = 1'b1;
                if (control_signal)
                    state_d = sipo_ctrl_pkg::st_armed;
            end
            default:
            begin
                state_d = sipo_ctrl_pkg::st_idle;
            end
        endcase
    end

    a_log_ready_exclusive: assert property (
        @(posedge clk2) disable iff (!reset_b)
        !(data_logging && data_ready)
    );

    // Logging window spans counter values 4 through 14, then drops.
    a_log_window: assert property (
        @(posedge clk2) disable iff (!reset_b)
        $rose(data_logging) |->
            counter_value == sipo_ctrl_pkg::lead_in_last + 1'b1
            ##(frame_pkg::frame_bits - 1)
            (data_logging && counter_value == sipo_ctrl_pkg::logging_last)
            ##1 !data_logging
    );

endmodule

`default_nettype wire

//--- rtl/sipo_ctrl_pkg.sv
`default_nettype none

package sipo_ctrl_pkg;

    // Capture controller states.
    typedef enum logic [2:0]
    {
        st_idle    = 3'd0,
        st_armed   = 3'd1,
        st_lead_in = 3'd2,
        st_logging = 3'd3,
        st_ready   = 3'd4
    } ctrl_state_e;

    // Cycle counter select codes.
    localparam logic [1:0] cnt_sel_clear = 2'b00;
    localparam logic [1:0] cnt_sel_count = 2'b11;
    localparam logic [1:0] cnt_sel_hold  = 2'b10;

    localparam int counter_width = 16;

    // Counter values that close the lead-in and the logging window.
    localparam logic [counter_width-1:0] lead_in_last = 16'd3;
    localparam logic [counter_width-1:0] logging_last = 16'd14;

    // Button debounce.
    localparam int debounce_cycles = 4;
    localparam int debounce_width  = $clog2(debounce_cycles);
    localparam logic [debounce_width-1:0] debounce_last = debounce_width'(debounce_cycles - 1);

endpackage

`default_nettype wire

//--- rtl/sipo_shift_reg.sv
`timescale 1ns/1ps
`default_nettype none

module sipo_shift_reg
(
    input  wire                      clk2,
    input  wire                      reset_b,
    input  wire                      data_logging,
    input  wire                      serial_in,
    output frame_pkg::frame_word_u   frame
);

    // First bit in ends at the top after a full frame.
    always_ff @(posedge clk2 or negedge reset_b)
    begin
        if (!reset_b)
        begin
            frame.raw <= '0;
        end
        else if (data_logging)
        begin
            frame.raw <= {frame.raw[frame_pkg::frame_bits-2:0], serial_in};
        end
    end

endmodule

`default_nettype wire

//--- rtl/sipo_top.sv
`timescale 1ns/1ps
`default_nettype none

module sipo_top
(
    input  wire                             clk2,
    input  wire                             reset_b,
    input  wire                             button,
    input  wire                             serial_in,
    output logic                            logging,
    output logic                            ready,
    output logic                            frame_done,
    output logic [frame_pkg::data_bits-1:0] data_byte,
    output logic                            parity_error,
    output logic                            framing_error
);

    logic                                   control_signal;
    logic [1:0]                             counter_sel;
    logic [sipo_ctrl_pkg::counter_width-1:0] counter_value;
    frame_pkg::frame_word_u                 frame_word;

    button_sync button_sync_i
    (
        .clk2           (clk2),
        .reset_b        (reset_b),
        .button         (button),
        .control_signal (control_signal)
    );

    cycle_counter cycle_counter_i
    (
        .clk2          (clk2),
        .reset_b       (reset_b),
        .counter_sel   (counter_sel),
        .counter_value (counter_value)
    );

    sipo_controller sipo_controller_i
    (
        .clk2           (clk2),
        .reset_b        (reset_b),
        .control_signal (control_signal),
        .counter_value  (counter_value),
        .counter_sel    (counter_sel),
        .data_logging   (logging),
        .data_ready     (ready)
    );

    sipo_shift_reg sipo_shift_reg_i
    (
        .clk2         (clk2),
        .reset_b      (reset_b),
        .data_logging (logging),
        .serial_in    (serial_in),
        .frame        (frame_word)
    );

    frame_decoder frame_decoder_i
    (
        .clk2          (clk2),
        .reset_b       (reset_b),
        .data_ready    (ready),
        .frame         (frame_word),
        .frame_done    (frame_done),
        .data_byte     (data_byte),
        .parity_error  (parity_error),
        .framing_error (framing_error)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module sipo_tb -Mdir obj_dir -o sipo_sim -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sipo_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0

//--- sim/sipo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sipo_tb;

    localparam int capture_count   = 8;
    localparam int cycles_per_test = 80;
    localparam int margin_cycles   = 200;
    localparam int clk_period      = 10;

    logic       clk2;
    logic       reset_b;
    logic       button;
    logic       serial_in;
    wire        logging;
    wire        ready;
    wire        frame_done;
    wire  [7:0] data_byte;
    wire        parity_error;
    wire        framing_error;

    integer     seed;
    logic [31:0] rnd;
    string      test_name;
    logic [7:0] exp_byte;
    logic       exp_parity_error;
    logic       exp_framing_error;
    logic       pressed;
    logic       short_window;
    logic [7:0] log_run;
    int         done_count;
    int         n;

    sipo_top dut_i
    (
        .clk2          (clk2),
        .reset_b       (reset_b),
        .button        (button),
        .serial_in     (serial_in),
        .logging       (logging),
        .ready         (ready),
        .frame_done    (frame_done),
        .data_byte     (data_byte),
        .parity_error  (parity_error),
        .framing_error (framing_error)
    );

    always #(clk_period / 2) clk2 = ~clk2;

    // Length of the current logging run, and frame_done pulses seen.
    always @(posedge clk2 or negedge reset_b)
    begin
        if (!reset_b)
        begin
            log_run    <= 8'd0;
            done_count <= 0;
        end
        else
        begin
            log_run <= logging ? log_run + 8'd1 : 8'd0;
            if (frame_done)
                done_count <= done_count + 1;
        end
    end

    a_quiet_before_press: assert property (@(posedge clk2) disable iff (!reset_b)
        !pressed |-> !(logging || ready || frame_done || parity_error || framing_error))
        else report_failure("an output left its reset level before the first press");

    a_short_pulse_ignored: assert property (@(posedge clk2) disable iff (!reset_b)
        short_window |-> !logging)
        else report_failure("a 2-cycle button pulse started a capture");

    a_logging_length: assert property (@(posedge clk2) disable iff (!reset_b)
        $fell(logging) |-> log_run == 8'd11)
        else report_mismatch("logging cycles", 8'd11, log_run);

    a_ready_follows: assert property (@(posedge clk2) disable iff (!reset_b)
        $fell(logging) |-> ready)
        else report_failure("ready did not rise on the edge after logging");

    a_ready_low_in_capture: assert property (@(posedge clk2) disable iff (!reset_b)
        logging |-> !ready)
        else report_failure("ready stayed high while a capture ran");

    a_done_one_cycle: assert property (@(posedge clk2) disable iff (!reset_b)
        frame_done |=> !frame_done)
        else report_failure("frame_done was high for more than one cycle");

    a_data_byte: assert property (@(posedge clk2) disable iff (!reset_b)
        frame_done |-> data_byte == exp_byte)
        else report_mismatch("data_byte", exp_byte, data_byte);

    a_parity_flag: assert property (@(posedge clk2) disable iff (!reset_b)
        frame_done |-> parity_error == exp_parity_error)
        else report_mismatch("parity_error", {7'd0, exp_parity_error}, {7'd0, parity_error});

    a_framing_flag: assert property (@(posedge clk2) disable iff (!reset_b)
        frame_done |-> framing_error == exp_framing_error)
        else report_mismatch("framing_error", {7'd0, exp_framing_error},
                             {7'd0, framing_error});

    task automatic stop_on_failure();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic report_failure(input string what);
        $display("Error in %s: %s", test_name, what);
        stop_on_failure();
    endtask

    task automatic report_mismatch(input string field, input logic [7:0] expected,
                                   input logic [7:0] actual);
        $display("Mismatch in %s on %s: expected 0x%02h, actual 0x%02h",
                 test_name, field, expected, actual);
        stop_on_failure();
    endtask

    // Called on a falling edge, returns on one.
    task automatic press_button(input int high_cycles);
        button = 1'b1;
        repeat (high_cycles) @(negedge clk2);
        button = 1'b0;
    endtask

    task automatic run_capture(input string name, input logic [7:0] data,
                               input logic flip_parity, input logic bad_start,
                               input logic bad_stop);
        logic [10:0] bits;
        int          i;
        test_name         = name;
        exp_byte          = data;
        exp_parity_error  = flip_parity;
        exp_framing_error = bad_start || bad_stop;
        // Start, data MSB first, even parity, stop.
        bits    = {bad_start, data, ^data ^ flip_parity, !bad_stop};
        pressed = 1'b1;
        press_button(12);
        while (!logging)
            @(negedge clk2);
        for (i = 10; i >= 0; i--)
        begin
            serial_in = bits[i];
            @(negedge clk2);
        end
        serial_in = 1'b1;
        while (!frame_done)
            @(negedge clk2);
        @(negedge clk2);
    endtask

    initial
    begin
        seed              = 32'h4c6e;
        clk2              = 1'b0;
        reset_b           = 1'b0;
        button            = 1'b0;
        serial_in         = 1'b1;
        pressed           = 1'b0;
        short_window      = 1'b0;
        test_name         = "reset";
        exp_byte          = 8'd0;
        exp_parity_error  = 1'b0;
        exp_framing_error = 1'b0;
        repeat (5) @(posedge clk2);
        @(negedge clk2);
        reset_b = 1'b1;
        repeat (10) @(negedge clk2);

        test_name    = "short_pulse";
        short_window = 1'b1;
        press_button(2);
        repeat (30) @(negedge clk2);
        short_window = 1'b0;

        for (n = 0; n < 4; n++)
        begin
            rnd = $random(seed);
            run_capture("valid_random", rnd[7:0], 1'b0, 1'b0, 1'b0);
        end
        rnd = $random(seed);
        run_capture("parity_flip", rnd[7:0], 1'b1, 1'b0, 1'b0);
        rnd = $random(seed);
        run_capture("bad_start", rnd[7:0], 1'b0, 1'b1, 1'b0);
        rnd = $random(seed);
        run_capture("bad_stop", rnd[7:0], 1'b0, 1'b0, 1'b1);
        rnd = $random(seed);
        run_capture("valid_after_errors", rnd[7:0], 1'b0, 1'b0, 1'b0);

        repeat (5) @(negedge clk2);
        test_name = "frame_done_count";
        if (done_count != capture_count)
        begin
            report_mismatch("pulses", 8'(capture_count), 8'(done_count));
        end
        else
        begin
            $display("TESTS PASSED");
            $finish;
        end
    end

    initial
    begin
        #((capture_count * cycles_per_test + margin_cycles) * clk_period);
        $display("Timeout: the captures did not finish in the allowed time.");
        stop_on_failure();
    end

endmodule

`default_nettype wire
